// ==== tb.f ====
+incdir+hdl
hdl/conv_ctrl_pkg.sv
hdl/conv_data_pkg.sv
hdl/n_delay.sv
hdl/multiplier.sv
hdl/accumulator.sv
hdl/pad_filter.sv
hdl/conv_engine.sv
verif/conv_engine_checker.sv
verif/conv_engine_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the conv_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module conv_engine_tb -f tb.f \
  --Mdir obj_dir -o conv_engine_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/conv_engine_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" <<< "$output"; then
  exit 0
fi

echo "Simulation did not report a pass"
exit 1

// ==== verif/conv_engine_tb.sv ====
`include "conv_settings.svh"

module conv_engine_tb
  import conv_ctrl_pkg::*;
  import conv_data_pkg::*;
();

  localparam int UNITS         = `UNITS;
  localparam int MEMBERS       = `MEMBERS;
  localparam int DATA_W        = $bits(acc_t) * MEMBERS * UNITS;
  localparam int ROWS          = 40;
  localparam int READY_TIMEOUT = 50;   // Enabled or not, cycles with the beat held
  localparam int DRAIN_TIMEOUT = 200;

  logic           clk;
  logic           clken;
  logic           rst_n;
  logic           s_valid;
  logic           s_ready;
  conv_in_beat_t  s_beat;
  logic           m_valid;
  conv_out_beat_t m_beat;

  integer seed;
  int     mismatches;
  int     extras;
  int     timeouts;
  int     results_seen;
  bit     aborted;

  conv_out_beat_t expected_q [$];
  acc_t           sums [MEMBERS][UNITS];  // Running S[m][u] of the open sequence

  conv_engine uut (
    .clk     (clk),
    .clken   (clken),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_beat  (s_beat),
    .m_valid (m_valid),
    .m_beat  (m_beat)
  );

  always #50 clk = ~clk;

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    if (actual !== expected) begin
      mismatches++;
      $display("** Error: %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // About 85% of cycles enabled
  task automatic next_cycle();
    @(negedge clk);
    clken = rand_below(100) < 85;
  endtask

  task automatic send_beat(input conv_in_beat_t beat);
    int waited;
    int bubbles;
    bit taken;
    waited  = 0;
    bubbles = 0;
    taken   = 1'b0;
    while (bubbles < 3 && rand_below(4) == 0) begin
      s_valid = 1'b0;
      bubbles++;
      next_cycle();
    end
    s_valid = 1'b1;
    s_beat  = beat;
    while (!taken && !aborted) begin
      @(posedge clk);
      taken = clken && s_ready;
      next_cycle();
      if (!taken) begin
        waited++;
        if (waited >= READY_TIMEOUT) begin
          $display("Timeout: beat not accepted after %0d cycles", waited);
          timeouts++;
          aborted = 1'b1;
        end
      end
    end
    s_valid = 1'b0;
  endtask

  task automatic add_beat(input conv_in_beat_t beat);
    pixel_t  pix;
    weight_t wt;
    acc_t    prod;
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        pix  = beat.pixels[u];
        wt   = beat.weights[m];
        prod = pix * wt;
        sums[m][u] = sums[m][u] + prod;  // Wraps at 24 bits
      end
    end
  endtask

  // Group starts keep their own sum, the rest add the left neighbour
  task automatic push_result(input kw2_t kw2, input logic row_last);
    conv_out_beat_t want;
    int             k;
    k = 2 * kw2 + 1;
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        if (m % k == 0)
          want.data[m][u] = sums[m][u];
        else
          want.data[m][u] = sums[m][u] + sums[m-1][u];
        want.keep[m][u] = '0;
        if (m % k == k - 1)
          want.keep[m][u] = '1;
      end
    end
    want.last = row_last;
    expected_q.push_back(want);
  endtask

  always @(posedge clk) begin
    conv_out_beat_t want;
    if (rst_n && clken && m_valid) begin
      if (expected_q.size() == 0) begin
        extras++;
        $display("Result %0d arrived with no result expected", results_seen);
      end else begin
        want = expected_q.pop_front();
        check_value($sformatf("result %0d data", results_seen), want.data, m_beat.data);
        check_value($sformatf("result %0d keep", results_seen), want.keep, m_beat.keep);
        check_value($sformatf("result %0d last", results_seen), want.last, m_beat.last);
      end
      results_seen++;
    end
  end

  initial begin
    int            n_seq;
    int            n_beats;
    int            col;
    int            waited;
    kw2_t          kw2;
    conv_in_beat_t beat;

    seed         = 9900;
    clk          = 1'b0;
    rst_n        = 1'b0;
    clken        = 1'b1;
    s_valid      = 1'b0;
    s_beat       = '0;
    mismatches   = 0;
    extras       = 0;
    timeouts     = 0;
    results_seen = 0;
    aborted      = 1'b0;

    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    check_value("m_valid after reset", 1'b0, m_valid);
    check_value("s_ready after reset", 1'b1, s_ready);

    for (int row = 0; row < ROWS && !aborted; row++) begin
      n_seq = 2 + rand_below(4);
      col   = 0;
      for (int s = 0; s < n_seq && !aborted; s++) begin
        kw2     = kw2_t'(rand_below(2));
        n_beats = 1 + rand_below(4);
        for (int m = 0; m < MEMBERS; m++) begin
          for (int u = 0; u < UNITS; u++)
            sums[m][u] = '0;
        end
        for (int b = 0; b < n_beats && !aborted; b++) begin
          for (int u = 0; u < UNITS; u++)
            beat.pixels[u] = pixel_t'($random(seed));
          for (int m = 0; m < MEMBERS; m++)
            beat.weights[m] = weight_t'($random(seed));
          beat.user.kw2         = kw2;
          beat.user.is_cin_last = (b == n_beats - 1);
          beat.user.is_row_last = (s == n_seq - 1);
          send_beat(beat);
          add_beat(beat);
        end
        if (!aborted && col >= kw2)  // Padded columns give no output
          push_result(kw2, s == n_seq - 1);
        col++;
      end
    end

    s_valid = 1'b0;
    waited  = 0;
    while (!aborted && expected_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!aborted && expected_q.size() != 0) begin
      $display("Timeout: %0d expected results never appeared", expected_q.size());
      timeouts++;
    end
    repeat (8) next_cycle();  // Room for stray outputs

    $display("Results: %0d, mismatches: %0d, unexpected: %0d, timeouts: %0d, assert fails: %0d",
             results_seen, mismatches, extras, timeouts, uut.chk.failures);
    if (mismatches == 0 && extras == 0 && timeouts == 0 && !aborted
        && uut.chk.failures == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== verif/conv_engine_checker.sv ====
module conv_engine_checker
  import conv_ctrl_pkg::*;
  import conv_data_pkg::*;
(
  input logic           clk,
  input logic           rst_n,
  input logic           clken,
  input logic           s_ready,
  input logic           m_valid,
  input conv_out_beat_t m_beat,
  input logic           mul_m_valid,
  input conv_user_t     mul_m_user
);

  logic stalled_last;  // s_ready low on the previous enabled cycle
  logic shift_due;     // Wide-kernel cin_last product seen on the previous enabled cycle
  int   failures = 0;  // Assertion failures so far

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stalled_last <= 1'b0;
      shift_due    <= 1'b0;
    end else if (clken) begin
      stalled_last <= !s_ready;
      shift_due    <= mul_m_valid && mul_m_user.is_cin_last && (mul_m_user.kw2 != '0);
    end
  end

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !m_valid)
    else begin
      failures++;
      $error("m_valid high during reset");
    end

  a_single_stall: assert property (@(posedge clk) disable iff (!rst_n)
    clken && stalled_last |-> s_ready)
    else begin
      failures++;
      $error("s_ready low on two enabled cycles in a row");
    end

  a_keep_present: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid |-> (m_beat.keep != '0))
    else begin
      failures++;
      $error("m_valid high with an empty keep");
    end

  a_stall_cause: assert property (@(posedge clk) disable iff (!rst_n)
    clken && !s_ready |-> shift_due)
    else begin
      failures++;
      $error("s_ready low without a wide-kernel cin_last product before it");
    end

endmodule

bind conv_engine conv_engine_checker chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .clken       (clken),
  .s_ready     (s_ready),
  .m_valid     (m_valid),
  .m_beat      (m_beat),
  .mul_m_valid (mul_m_valid),
  .mul_m_user  (mul_m_user)
);

// ==== hdl/conv_engine.sv ====
`include "conv_settings.svh"

module conv_engine
  import conv_ctrl_pkg::*;
  import conv_data_pkg::*;
(
  input  logic           clk,
  input  logic           clken,
  input  logic           rst_n,
  input  logic           s_valid,
  output logic           s_ready,
  input  conv_in_beat_t  s_beat,
  output logic           m_valid,
  output conv_out_beat_t m_beat
);

  localparam int UNITS   = `UNITS;
  localparam int MEMBERS = `MEMBERS;
  localparam int KW2_MAX = `KW_MAX / 2;
  localparam int KEEP_W  = `WORD_WIDTH_ACC / 8;

  logic       clken_mul;
  logic       mux_sel, mux_sel_next;
  logic       mul_m_valid;
  logic       acc_m_valid_next, acc_m_valid;
  conv_user_t mul_m_user, acc_m_user;

  logic                          valid_mask;
  logic [MEMBERS-1:0]            keep_mask;
  logic [MEMBERS-1:0]            acc_s_valid, clken_acc;
  logic [MEMBERS-1:0]            bypass, bypass_next;
  logic [MEMBERS-1:0]            mul_start, acc_start;
  logic [KW2_MAX:0][MEMBERS-1:0] start_lut;

  product_t mul_m_data [MEMBERS][UNITS];
  acc_t     acc_s_data [MEMBERS][UNITS];
  acc_t     acc_m_data [MEMBERS][UNITS];

  for (genvar m = 0; m < MEMBERS; m++) begin : g_mul_m
    for (genvar u = 0; u < UNITS; u++) begin : g_mul_u
      multiplier mul (
        .clk   (clk),
        .clken (clken_mul),
        .a     (s_beat.pixels[u]),
        .b     (s_beat.weights[m]),
        .p     (mul_m_data[m][u])
      );
    end
  end

  // Valid and user ride along with the products
  n_delay #(
    .N     (`LATENCY_MULTIPLIER),
    .WIDTH (1 + $bits(conv_user_t))
  ) mul_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .clken    (clken_mul),
    .data_in  ({s_valid, s_beat.user}),
    .data_out ({mul_m_valid, mul_m_user})
  );

  // One shift cycle after a wide-kernel sequence ends
  assign mux_sel_next = !mux_sel && mul_m_valid && mul_m_user.is_cin_last
                        && (mul_m_user.kw2 != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      mux_sel <= 1'b0;
    else if (clken)
      mux_sel <= mux_sel_next;
  end

  assign clken_mul = clken && !mux_sel;  // Input and multipliers stall on shift
  assign s_ready   = clken_mul;

  always_comb begin
    for (int k = 0; k <= KW2_MAX; k++) begin
      for (int m = 0; m < MEMBERS; m++)
        start_lut[k][m] = (m % (2*k + 1)) == 0;
    end
  end

  assign mul_start = start_lut[mul_m_user.kw2];
  assign acc_start = start_lut[acc_m_user.kw2];  // Kernel of the sequence being shifted

  for (genvar m = 0; m < MEMBERS; m++) begin : g_ctrl
    assign acc_s_valid[m] = mux_sel ? !acc_start[m] : mul_m_valid;
    assign clken_acc[m]   = clken && acc_s_valid[m];
    // Non-start members keep summing through the shift
    assign bypass_next[m] = mux_sel || (mul_m_user.is_cin_last && mul_start[m]);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bypass <= '1;
    end else begin
      for (int m = 0; m < MEMBERS; m++) begin
        if (clken_acc[m])
          bypass[m] <= bypass_next[m];
      end
    end
  end

  for (genvar m = 0; m < MEMBERS; m++) begin : g_acc_m
    for (genvar u = 0; u < UNITS; u++) begin : g_acc_u
      acc_t shift_in;

      if (m == 0) begin : g_edge
        assign shift_in = '0;  // Member 0 always starts a group
      end else begin : g_inner
        assign shift_in = acc_m_data[m-1][u];
      end

      assign acc_s_data[m][u] = mux_sel ? shift_in : acc_t'(mul_m_data[m][u]);

      accumulator acc (
        .clk    (clk),
        .rst_n  (rst_n),
        .clken  (clken_acc[m]),
        .bypass (bypass[m]),
        .b      (acc_s_data[m][u]),
        .q      (acc_m_data[m][u])
      );
    end
  end

  // Holds the user of the last summed beat through the shift
  n_delay #(
    .N     (`LATENCY_ACCUMULATOR),
    .WIDTH ($bits(conv_user_t))
  ) acc_user_dly (
    .clk      (clk),
    .rst_n    (rst_n),
    .clken    (clken_mul && mul_m_valid),
    .data_in  (mul_m_user),
    .data_out (acc_m_user)
  );

  assign acc_m_valid_next = mux_sel
                            || (mul_m_valid && mul_m_user.is_cin_last
                                && (mul_m_user.kw2 == '0));

  n_delay #(
    .N     (`LATENCY_ACCUMULATOR),
    .WIDTH (1)
  ) acc_valid_dly (
    .clk      (clk),
    .rst_n    (rst_n),
    .clken    (clken),
    .data_in  (acc_m_valid_next),
    .data_out (acc_m_valid)
  );

  pad_filter pad (
    .clk        (clk),
    .rst_n      (rst_n),
    .clken      (clken),
    .valid_in   (acc_m_valid),
    .user_in    (acc_m_user),
    .valid_mask (valid_mask),
    .keep_mask  (keep_mask)
  );

  assign m_valid = acc_m_valid && valid_mask;

  always_comb begin
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        m_beat.data[m][u] = acc_m_data[m][u];
        m_beat.keep[m][u] = {KEEP_W{keep_mask[m]}};
      end
    end
    m_beat.last = acc_m_user.is_row_last;
  end

endmodule

// ==== hdl/pad_filter.sv ====
`include "conv_settings.svh"

module pad_filter
  import conv_ctrl_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clken,
  input  logic                valid_in,
  input  conv_user_t          user_in,
  output logic                valid_mask,
  output logic [`MEMBERS-1:0] keep_mask
);

  localparam int MEMBERS = `MEMBERS;
  localparam int KW2_MAX = `KW_MAX / 2;

  kw2_t                          col_count;  // Results so far in this row
  logic [KW2_MAX:0][MEMBERS-1:0] keep_lut;

  // Saturates once past the padded columns
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_count <= '0;
    end else if (clken && valid_in) begin
      if (user_in.is_row_last)
        col_count <= '0;
      else if (col_count != '1)
        col_count <= col_count + 1'b1;
    end
  end

  // Last member of each kernel group holds the finished sum
  always_comb begin
    for (int k = 0; k <= KW2_MAX; k++) begin
      for (int m = 0; m < MEMBERS; m++)
        keep_lut[k][m] = (m % (2*k + 1)) == 2*k;
    end
  end

  // Leading kw2 columns of a row are padding
  assign valid_mask = col_count >= user_in.kw2;
  assign keep_mask  = keep_lut[user_in.kw2];

endmodule

// ==== hdl/accumulator.sv ====
module accumulator
  import conv_data_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic clken,
  input  logic bypass,  // Start a new sum from b
  input  acc_t b,
  output acc_t q
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      q <= '0;
    else if (clken)
      q <= bypass ? b : q + b;  // Wraps at the word width
  end

endmodule

// ==== hdl/multiplier.sv ====
`include "conv_settings.svh"

module multiplier
  import conv_data_pkg::*;
(
  input  logic     clk,
  input  logic     clken,
  input  pixel_t   a,
  input  weight_t  b,
  output product_t p
);

  localparam int LATENCY = `LATENCY_MULTIPLIER;

  product_t pipe [LATENCY];

  // Product register plus extra stages, retimed into the DSP
  always_ff @(posedge clk) begin
    if (clken) begin
      pipe[0] <= a * b;
      for (int i = 1; i < LATENCY; i++)
        pipe[i] <= pipe[i-1];
    end
  end

  assign p = pipe[LATENCY-1];

endmodule

// ==== hdl/n_delay.sv ====
module n_delay #(
  parameter int N     = 1,
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clken,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  logic [WIDTH-1:0] stage [N];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < N; i++)
        stage[i] <= '0;
    end else if (clken) begin
      stage[0] <= data_in;
      for (int i = 1; i < N; i++)
        stage[i] <= stage[i-1];
    end
  end

  assign data_out = stage[N-1];  // Oldest stage

endmodule

// ==== hdl/conv_data_pkg.sv ====
`include "conv_settings.svh"

package conv_data_pkg;

  typedef logic signed [`WORD_WIDTH-1:0]     pixel_t;
  typedef logic signed [`WORD_WIDTH-1:0]     weight_t;
  typedef logic signed [2*`WORD_WIDTH-1:0]   product_t;
  typedef logic signed [`WORD_WIDTH_ACC-1:0] acc_t;

  // One keep bit per byte of an accumulator word
  typedef logic [`WORD_WIDTH_ACC/8-1:0] acc_keep_t;

  // Input beat, pixels are shared by all members
  typedef struct packed {
    pixel_t  [`UNITS-1:0]       pixels;
    weight_t [`MEMBERS-1:0]     weights;
    conv_ctrl_pkg::conv_user_t  user;
  } conv_in_beat_t;

  // Output beat, one word per member and unit
  typedef struct packed {
    acc_t      [`MEMBERS-1:0][`UNITS-1:0] data;
    acc_keep_t [`MEMBERS-1:0][`UNITS-1:0] keep;
    logic                                 last;  // Row ends with this result
  } conv_out_beat_t;

endpackage

// ==== hdl/conv_ctrl_pkg.sv ====
`include "conv_settings.svh"

package conv_ctrl_pkg;

  // Half kernel width, the kernel is 2*kw2 + 1 columns wide
  typedef logic [`BITS_KW2-1:0] kw2_t;

  // Control word carried alongside every input beat
  typedef struct packed {
    kw2_t kw2;
    logic is_cin_last;  // Final channel of a column
    logic is_row_last;  // Final column of a row
  } conv_user_t;

endpackage

// ==== hdl/conv_settings.svh ====
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// Beat geometry
`define UNITS                2    // Pixels per beat
`define MEMBERS              4    // Weights and accumulator columns per beat

// Word widths
`define WORD_WIDTH           8    // Pixel and weight
`define WORD_WIDTH_ACC       24

// Pipeline depths, in enabled cycles
`define LATENCY_MULTIPLIER   2
`define LATENCY_ACCUMULATOR  1

// Kernel width support, K = 2*kw2 + 1
`define KW_MAX               3
`define BITS_KW2             1

`endif
